// ==== all.f ====
design/soc_pkg.sv
design/pi1_addr_decoder.sv
design/device_table.sv
design/reset_sequencer.sv
design/activity_dimmer.sv
design/platform_top.sv
dv/tb_platform.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_platform
RTL_TOP   ?= platform_top
FILELIST  ?= all.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_platform.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_platform;
	import soc_pkg::*;

	localparam int TIMEOUT_CYCLES = 2000;

	logic        clk_2x_w = 1'b0;
	logic        rst_p;
	pi1_op_t     pi1_op;
	logic [29:0] pi1_addr;
	logic [31:0] pi1_wdata;
	logic [3:0]  pi1_sel;
	logic [31:0] ext_data_i;
	logic        ext_rdy_i;
	logic        fault_i;
	wire [31:0]  pi1_rdata;
	wire         pi1_rdy;
	pi1_op_t     ext_op;
	wire [29:0]  ext_addr;
	wire [31:0]  ext_wdata;
	wire [3:0]   ext_sel;
	wire         sys_rst;
	wire         activity;

	// Expected device descriptors
	logic [15:0] exp_id [7] = '{16'd7, 16'd4, 16'd9, 16'd6, 16'd6, 16'd3, 16'd5};
	logic        exp_intr [7] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};

	int          errors = 0;
	int          tests_run = 0;
	int          tests_bad = 0;
	int          cycles = 0;
	int          stall_cnt = 0;
	int          ext_cnt = 0;
	logic [3:0]  req_sel = 4'hf;
	logic [29:0] ext_wr_addr;
	logic [31:0] ext_wr_data;
	logic [3:0]  ext_wr_sel;

	platform_top #(
		.RST_CNTR_BITSZ      (4),
		.ACTIVITY_CNTR_BITSZ (3)
	) dut_i (
		.clk_2x_w   (clk_2x_w),
		.rst_p      (rst_p),
		.pi1_op_i   (pi1_op),
		.pi1_addr_i (pi1_addr),
		.pi1_data_i (pi1_wdata),
		.pi1_sel_i  (pi1_sel),
		.ext_data_i (ext_data_i),
		.ext_rdy_i  (ext_rdy_i),
		.fault_i    (fault_i),
		.pi1_data_o (pi1_rdata),
		.pi1_rdy_o  (pi1_rdy),
		.ext_op_o   (ext_op),
		.ext_addr_o (ext_addr),
		.ext_data_o (ext_wdata),
		.ext_sel_o  (ext_sel),
		.sys_rst_o  (sys_rst),
		.activity_o (activity)
	);

	always #5 clk_2x_w = ~clk_2x_w;

	always @(posedge clk_2x_w) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] ext_word(input logic [29:0] addr);
		ext_word = {addr[15:0], ~addr[15:0]};
	endfunction

	// External slave, read data follows one cycle after acceptance
	always @(posedge clk_2x_w) begin
		if (ext_op != PINOOP && ext_rdy_i) begin
			ext_cnt++;
			if (ext_op == PIWROP) begin
				ext_wr_addr = ext_addr;
				ext_wr_data = ext_wdata;
				ext_wr_sel  = ext_sel;
			end else begin
				ext_data_i <= #1 ext_word(ext_addr);
			end
		end
		#1;
		if (stall_cnt > 0) begin
			ext_rdy_i = 1'b0;
			stall_cnt--;
		end else begin
			ext_rdy_i = 1'b1;
		end
	end

	task automatic mismatch(input string msg);
		$display("FAILED at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (errors != errs_before) begin
			tests_bad++;
			$display("%s: %0d errors", name, errors - errs_before);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	// One request, held until ready; returns the data of the next cycle
	task automatic bus_op(input pi1_op_t op, input logic [29:0] addr, input logic [31:0] wd,
			output logic [31:0] rd, output int waits);
		@(posedge clk_2x_w);
		#1;
		pi1_op    = op;
		pi1_addr  = addr;
		pi1_wdata = wd;
		pi1_sel   = req_sel;
		waits     = 0;
		@(negedge clk_2x_w);
		while (!pi1_rdy && waits < 100) begin
			waits++;
			@(negedge clk_2x_w);
		end
		@(posedge clk_2x_w);
		#1;
		pi1_op = PINOOP;
		@(negedge clk_2x_w);
		rd = pi1_rdata;
	endtask

	// Board reset for 2 cycles, then the release count
	task automatic reset_and_release();
		@(posedge clk_2x_w);
		#1;
		rst_p = 1'b1;
		repeat (2) @(posedge clk_2x_w);
		#1;
		rst_p = 1'b0;
		@(posedge clk_2x_w);
		for (int k = 0; k <= 15; k++) begin
			@(negedge clk_2x_w);
			if (sys_rst !== (k < 15))
				mismatch($sformatf("sys_rst_o is %b, %0d cycles after release", sys_rst, k));
			if (activity !== 1'b0)
				mismatch("activity_o high during reset");
			if (k < 15)
				@(posedge clk_2x_w);
		end
	endtask

	task automatic test_reset_release();
		int e0;
		e0 = errors;
		reset_and_release();
		finish_test("reset release", e0);
	endtask

	task automatic test_device_table();
		int e0;
		int w;
		logic [31:0] rd;
		e0 = errors;
		for (int k = 0; k < 7; k++) begin
			bus_op(PIRDOP, 30'(2 * k), 32'h0, rd, w);
			if (rd !== {15'd0, exp_intr[k], exp_id[k]})
				mismatch($sformatf("descriptor of device %0d reads %h", k, rd));
			bus_op(PIRDOP, 30'(2 * k + 1), 32'h0, rd, w);
			if (rd !== 32'd4096)
				mismatch($sformatf("map size of device %0d reads %h", k, rd));
		end
		bus_op(PIRDOP, 30'd14, 32'h0, rd, w);
		if (rd !== 32'h0)
			mismatch($sformatf("word 14 reads %h", rd));
		finish_test("device table", e0);
	endtask

	task automatic test_routing();
		int e0;
		int w;
		int cnt0;
		logic [31:0] rd;
		logic [31:0] d;
		e0 = errors;
		d = $urandom;
		req_sel = 4'h6;
		bus_op(PIWROP, 30'h405, d, rd, w);
		req_sel = 4'hf;
		if (ext_wr_addr !== 30'h405 || ext_wr_data !== d || ext_wr_sel !== 4'h6)
			mismatch($sformatf("ext write saw %h/%h/%h", ext_wr_addr, ext_wr_data,
				ext_wr_sel));
		bus_op(PIRDOP, 30'h1234, 32'h0, rd, w);
		if (rd !== ext_word(30'h1234))
			mismatch($sformatf("ext read returned %h", rd));
		stall_cnt = 3;
		bus_op(PIRDOP, 30'h1bff, 32'h0, rd, w);
		if (w != 3)
			mismatch($sformatf("pi1_rdy_o low for %0d cycles, expected 3", w));
		if (rd !== ext_word(30'h1bff))
			mismatch($sformatf("stalled ext read returned %h", rd));
		cnt0 = ext_cnt;
		bus_op(PIRDOP, 30'h1c00, 32'h0, rd, w);
		if (rd !== 32'h0 || w != 0)
			mismatch($sformatf("invalid read gave %h after %0d waits", rd, w));
		bus_op(PIWROP, 30'h3fff_ffff, $urandom, rd, w);
		if (ext_cnt != cnt0)
			mismatch("request above the map reached the ext port");
		finish_test("routing", e0);
	endtask

	task automatic test_soft_reset(input logic [31:0] code, input string name);
		int e0;
		int w;
		int high;
		logic [31:0] rd;
		e0 = errors;
		bus_op(PIWROP, 30'd1023, code, rd, w);
		if (sys_rst !== 1'b0)
			mismatch("sys_rst_o rose in the cycle of acceptance");
		high = 0;
		@(negedge clk_2x_w);
		while (sys_rst === 1'b1 && high < 40) begin
			high++;
			@(negedge clk_2x_w);
		end
		// Bits clear one cycle after the rise, then 15 cycles of count
		if (high != 16)
			mismatch($sformatf("sys_rst_o high for %0d cycles, expected 16", high));
		bus_op(PIRDOP, 30'd1023, 32'h0, rd, w);
		if (rd !== 32'h0)
			mismatch($sformatf("control word reads %h", rd));
		finish_test(name, e0);
	endtask

	task automatic test_power_off();
		int e0;
		int w;
		logic [31:0] rd;
		e0 = errors;
		bus_op(PIWROP, 30'd1023, 32'd1, rd, w);
		@(negedge clk_2x_w);
		for (int k = 0; k < 45; k++) begin
			if (sys_rst !== 1'b1)
				mismatch($sformatf("sys_rst_o dropped %0d cycles into power-off", k));
			@(negedge clk_2x_w);
		end
		reset_and_release();
		finish_test("power-off", e0);
	endtask

	// Pulse in the cycle after the first event, then every 8 cycles
	task automatic check_pulses(input string what);
		for (int i = 0; i < 24; i++) begin
			@(negedge clk_2x_w);
			if (activity !== (i % 8 == 1))
				mismatch($sformatf("%s: activity_o is %b at cycle %0d", what, activity, i));
		end
	endtask

	task automatic test_activity();
		int e0;
		e0 = errors;
		repeat (10) @(posedge clk_2x_w);
		#1;
		pi1_op   = PIRDOP;
		pi1_addr = 30'd0;
		check_pulses("bus");
		@(posedge clk_2x_w);
		#1;
		pi1_op = PINOOP;
		repeat (10) @(posedge clk_2x_w);
		#1;
		fault_i = 1'b1;
		check_pulses("fault");
		@(posedge clk_2x_w);
		#1;
		fault_i = 1'b0;
		finish_test("activity", e0);
	endtask

	initial begin
		void'($urandom(32'hba6c));
		rst_p      = 1'b1;
		pi1_op     = PINOOP;
		pi1_addr   = '0;
		pi1_wdata  = '0;
		pi1_sel    = '0;
		ext_data_i = '0;
		ext_rdy_i  = 1'b1;
		fault_i    = 1'b0;
		test_reset_release();
		test_device_table();
		test_routing();
		test_soft_reset(32'd2, "warm reset");
		test_soft_reset(32'd3, "cold reset");
		test_power_off();
		test_activity();
		$display("Summary: %0d tests, %0d failed, %0d check errors", tests_run, tests_bad,
			errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/platform_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module platform_top #(
	parameter int RST_CNTR_BITSZ      = 16,
	parameter int ACTIVITY_CNTR_BITSZ = 7
) (
	input  wire                             clk_2x_w,
	input  wire                             rst_p,
	input  wire soc_pkg::pi1_op_t           pi1_op_i,
	input  wire [soc_pkg::ADDRBITSZ-1:0]    pi1_addr_i,
	input  wire [soc_pkg::ARCHBITSZ-1:0]    pi1_data_i,
	input  wire [soc_pkg::ARCHBITSZ/8-1:0]  pi1_sel_i,
	input  wire [soc_pkg::ARCHBITSZ-1:0]    ext_data_i,
	input  wire                             ext_rdy_i,
	input  wire                             fault_i,
	output wire [soc_pkg::ARCHBITSZ-1:0]    pi1_data_o,
	output wire                             pi1_rdy_o,
	output wire soc_pkg::pi1_op_t           ext_op_o,
	output wire [soc_pkg::ADDRBITSZ-1:0]    ext_addr_o,
	output wire [soc_pkg::ARCHBITSZ-1:0]    ext_data_o,
	output wire [soc_pkg::ARCHBITSZ/8-1:0]  ext_sel_o,
	output wire                             sys_rst_o,
	output wire                             activity_o
);
	import soc_pkg::*;

	// Device table side of the decoder
	wire pi1_op_t                 dt_op_w;
	wire [DEVTBL_ADDRBITSZ-1:0]   dt_addr_w;
	wire [ARCHBITSZ-1:0]          dt_wdata_w;
	wire [ARCHBITSZ-1:0]          dt_rdata_w;
	wire [ARCHBITSZ/8-1:0]        dt_sel_w;

	wire soft_rst0_w;
	wire soft_rst1_w;

	pi1_addr_decoder u_decoder (
		.clk_2x_w   (clk_2x_w),
		.rst_p      (rst_p),
		.pi1_op_i   (pi1_op_i),
		.pi1_addr_i (pi1_addr_i),
		.pi1_data_i (pi1_data_i),
		.pi1_sel_i  (pi1_sel_i),
		.pi1_data_o (pi1_data_o),
		.pi1_rdy_o  (pi1_rdy_o),
		.dt_op_o    (dt_op_w),
		.dt_addr_o  (dt_addr_w),
		.dt_data_i  (dt_rdata_w),
		.dt_data_o  (dt_wdata_w),
		.dt_sel_o   (dt_sel_w),
		.ext_op_o   (ext_op_o),
		.ext_addr_o (ext_addr_o),
		.ext_data_i (ext_data_i),
		.ext_data_o (ext_data_o),
		.ext_sel_o  (ext_sel_o),
		.ext_rdy_i  (ext_rdy_i)
	);

	// Software reset clears the table through the system reset
	device_table u_devtbl (
		.clk_2x_w    (clk_2x_w),
		.rst_i       (sys_rst_o),
		.op_i        (dt_op_w),
		.addr_i      (dt_addr_w),
		.data_i      (dt_wdata_w),
		.sel_i       (dt_sel_w),
		.data_o      (dt_rdata_w),
		.soft_rst0_o (soft_rst0_w),
		.soft_rst1_o (soft_rst1_w)
	);

	reset_sequencer #(
		.RST_CNTR_BITSZ (RST_CNTR_BITSZ)
	) u_rstseq (
		.clk_2x_w    (clk_2x_w),
		.rst_p       (rst_p),
		.soft_rst0_i (soft_rst0_w),
		.soft_rst1_i (soft_rst1_w),
		.sys_rst_o   (sys_rst_o)
	);

	activity_dimmer #(
		.ACTIVITY_CNTR_BITSZ (ACTIVITY_CNTR_BITSZ)
	) u_dimmer (
		.clk_2x_w   (clk_2x_w),
		.rst_p      (rst_p),
		.pi1_op_i   (pi1_op_i),
		.pi1_rdy_i  (pi1_rdy_o),
		.fault_i    (fault_i),
		.activity_o (activity_o)
	);

endmodule

`default_nettype wire

// ==== design/activity_dimmer.sv ====
`timescale 1ns/1ps
`default_nettype none

module activity_dimmer #(
	parameter int ACTIVITY_CNTR_BITSZ = 7
) (
	input  wire                   clk_2x_w,
	input  wire                   rst_p,
	input  wire soc_pkg::pi1_op_t pi1_op_i,
	input  wire                   pi1_rdy_i,
	input  wire                   fault_i,
	output logic                  activity_o
);
	import soc_pkg::*;

	logic                           event_w;
	logic [ACTIVITY_CNTR_BITSZ-1:0] dim_cntr_q;

	// Accepted bus request or a fault
	assign event_w = ((pi1_op_i != PINOOP) && pi1_rdy_i) || fault_i;

	// One cycle of light, then a dark stretch that ignores events
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			activity_o <= 1'b0;
			dim_cntr_q <= '0;
		end else if (dim_cntr_q != '0) begin
			activity_o <= 1'b0;
			dim_cntr_q <= dim_cntr_q - 1'b1;
		end else if (event_w) begin
			activity_o <= 1'b1;
			dim_cntr_q <= '1;
		end else begin
			activity_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/reset_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
	parameter int RST_CNTR_BITSZ = 16
) (
	input  wire  clk_2x_w,
	input  wire  rst_p,
	input  wire  soft_rst0_i,
	input  wire  soft_rst1_i,
	output logic sys_rst_o
);

	logic                      swcoldrst_w;
	logic                      swwarmrst_w;
	logic                      swpwroff_w;
	logic                      rst_p_q;
	logic                      pwroff_q;
	logic [RST_CNTR_BITSZ-1:0] rst_cntr_q;

	// Request decode, a cold reset is handled like a warm one
	assign swcoldrst_w = soft_rst0_i && soft_rst1_i;
	assign swwarmrst_w = !soft_rst0_i && soft_rst1_i;
	assign swpwroff_w  = soft_rst0_i && !soft_rst1_i;

	// Holds the reload one edge past rst_p release
	always_ff @(posedge clk_2x_w) begin
		rst_p_q <= rst_p;
	end

	always_ff @(posedge clk_2x_w) begin
		if (rst_p || rst_p_q || swwarmrst_w || swcoldrst_w) begin
			rst_cntr_q <= '1;
		end else if (rst_cntr_q != '0) begin
			rst_cntr_q <= rst_cntr_q - 1'b1;
		end
	end

	// Power-off stays latched until the board reset
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (swpwroff_w) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = (rst_cntr_q != '0) || pwroff_q;

endmodule

`default_nettype wire

// ==== design/device_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module device_table (
	input  wire                                  clk_2x_w,
	input  wire                                  rst_i,
	input  wire soc_pkg::pi1_op_t                op_i,
	input  wire [soc_pkg::DEVTBL_ADDRBITSZ-1:0]  addr_i,
	input  wire [soc_pkg::ARCHBITSZ-1:0]         data_i,
	input  wire [soc_pkg::ARCHBITSZ/8-1:0]       sel_i,
	output logic [soc_pkg::ARCHBITSZ-1:0]        data_o,
	output logic                                 soft_rst0_o,
	output logic                                 soft_rst1_o
);
	import soc_pkg::*;

	localparam logic [DEVTBL_ADDRBITSZ-1:0] CTRL_ADDR =
		DEVTBL_ADDRBITSZ'(DEVTBL_CTRL_WORD);
	// First offset past the descriptor and size pairs
	localparam logic [DEVTBL_ADDRBITSZ-1:0] DESC_END =
		DEVTBL_ADDRBITSZ'(2 * DEV_COUNT);
	localparam int DEV_IDX_BITSZ = $bits(dev_idx_t);

	devtbl_word_u rd_word_w;
	dev_idx_t     dev_w;
	logic         rd_en_w;
	logic         ctrl_wr_w;

	// Two words per device, descriptor then map size
	always_comb begin
		dev_w     = dev_idx_t'(addr_i[DEV_IDX_BITSZ:1]);
		rd_word_w = '0;
		if (addr_i == CTRL_ADDR) begin
			rd_word_w.mapsz = {{(ARCHBITSZ - 2){1'b0}}, soft_rst1_o, soft_rst0_o};
		end else if (addr_i < DESC_END) begin
			if (addr_i[0]) begin
				rd_word_w.mapsz = DEV_MAPSZ_BYTES;
			end else begin
				rd_word_w.desc.useintr = DEV_USEINTR[dev_w];
				rd_word_w.desc.id      = DEV_ID[dev_w];
			end
		end
	end

	assign rd_en_w   = (op_i == PIRDOP) || (op_i == PIRWOP);
	assign ctrl_wr_w = (op_i == PIWROP) && (addr_i == CTRL_ADDR) && sel_i[0];

	always_ff @(posedge clk_2x_w) begin
		if (rd_en_w) begin
			data_o <= rd_word_w;
		end
	end

	// Software reset control, bit 0 and bit 1
	always_ff @(posedge clk_2x_w) begin
		if (rst_i) begin
			soft_rst0_o <= 1'b0;
			soft_rst1_o <= 1'b0;
		end else if (ctrl_wr_w) begin
			soft_rst0_o <= data_i[0];
			soft_rst1_o <= data_i[1];
		end
	end

endmodule

`default_nettype wire

// ==== design/pi1_addr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module pi1_addr_decoder (
	input  wire                                  clk_2x_w,
	input  wire                                  rst_p,
	input  wire soc_pkg::pi1_op_t                pi1_op_i,
	input  wire [soc_pkg::ADDRBITSZ-1:0]         pi1_addr_i,
	input  wire [soc_pkg::ARCHBITSZ-1:0]         pi1_data_i,
	input  wire [soc_pkg::ARCHBITSZ/8-1:0]       pi1_sel_i,
	output logic [soc_pkg::ARCHBITSZ-1:0]        pi1_data_o,
	output logic                                 pi1_rdy_o,
	output soc_pkg::pi1_op_t                     dt_op_o,
	output logic [soc_pkg::DEVTBL_ADDRBITSZ-1:0] dt_addr_o,
	input  wire [soc_pkg::ARCHBITSZ-1:0]         dt_data_i,
	output logic [soc_pkg::ARCHBITSZ-1:0]        dt_data_o,
	output logic [soc_pkg::ARCHBITSZ/8-1:0]      dt_sel_o,
	output soc_pkg::pi1_op_t                     ext_op_o,
	output logic [soc_pkg::ADDRBITSZ-1:0]        ext_addr_o,
	input  wire [soc_pkg::ARCHBITSZ-1:0]         ext_data_i,
	output logic [soc_pkg::ARCHBITSZ-1:0]        ext_data_o,
	output logic [soc_pkg::ARCHBITSZ/8-1:0]      ext_sel_o,
	input  wire                                  ext_rdy_i
);
	import soc_pkg::*;

	localparam logic [ADDRBITSZ-1:0] DT_LAST  = ADDRBITSZ'(DEVTBL_WORDS - 1);
	localparam logic [ADDRBITSZ-1:0] EXT_LAST = ADDRBITSZ'(EXT_LAST_WORD);

	// Target codes
	localparam logic [1:0] TGT_DT  = 2'd0;
	localparam logic [1:0] TGT_EXT = 2'd1;
	localparam logic [1:0] TGT_INV = 2'd2;

	logic [1:0] tgt_w;
	logic       rd_acc_w;
	logic [1:0] rd_tgt_q;

	always_comb begin
		if (pi1_addr_i <= DT_LAST) begin
			tgt_w = TGT_DT;
		end else if (pi1_addr_i <= EXT_LAST) begin
			tgt_w = TGT_EXT;
		end else begin
			tgt_w = TGT_INV;
		end
	end

	// Only the selected target sees the op, writes above the map are dropped
	always_comb begin
		dt_op_o    = (tgt_w == TGT_DT) ? pi1_op_i : PINOOP;
		dt_addr_o  = pi1_addr_i[DEVTBL_ADDRBITSZ-1:0];
		dt_data_o  = pi1_data_i;
		dt_sel_o   = pi1_sel_i;
		ext_op_o   = (tgt_w == TGT_EXT) ? pi1_op_i : PINOOP;
		ext_addr_o = pi1_addr_i;
		ext_data_o = pi1_data_i;
		ext_sel_o  = pi1_sel_i;
	end

	// Device table and invalid responder never stall
	assign pi1_rdy_o = (tgt_w == TGT_EXT) ? ext_rdy_i : 1'b1;

	assign rd_acc_w = pi1_rdy_o && ((pi1_op_i == PIRDOP) || (pi1_op_i == PIRWOP));

	// Remember who owns the read data of the next cycle
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			rd_tgt_q <= TGT_INV;
		end else if (rd_acc_w) begin
			rd_tgt_q <= tgt_w;
		end
	end

	always_comb begin
		case (rd_tgt_q)
			TGT_DT:  pi1_data_o = dt_data_i;
			TGT_EXT: pi1_data_o = ext_data_i;
			// Invalid device reads as zero
			default: pi1_data_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

	// Bus geometry
	localparam int ARCHBITSZ = 32;
	localparam int ADDRBITSZ = ARCHBITSZ - $clog2(ARCHBITSZ / 8);

	typedef enum logic [1:0] {
		PINOOP = 2'b00,
		PIWROP = 2'b01,
		PIRDOP = 2'b10,
		// Read-write swap, served as a plain read
		PIRWOP = 2'b11
	} pi1_op_t;

	// Device order as listed in the device table
	typedef enum logic [2:0] {
		DEV_DEVTBL,
		DEV_SDCARD,
		DEV_PWM0,
		DEV_GP0IO,
		DEV_GP1IO,
		DEV_INTCTRL,
		DEV_UART
	} dev_idx_t;

	localparam int DEV_COUNT = 7;

	localparam logic [15:0] DEV_ID [DEV_COUNT] = '{
		16'd7, 16'd4, 16'd9, 16'd6, 16'd6, 16'd3, 16'd5
	};

	localparam logic DEV_USEINTR [DEV_COUNT] = '{
		1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1
	};

	// Every device maps 4 KB
	localparam logic [ARCHBITSZ-1:0] DEV_MAPSZ_BYTES = 32'h0000_1000;

	localparam int DEVTBL_WORDS     = 1024;
	localparam int DEVTBL_ADDRBITSZ = $clog2(DEVTBL_WORDS);
	localparam int DEVTBL_CTRL_WORD = DEVTBL_WORDS - 1;

	// Remaining devices sit back to back after the device table window
	localparam int EXT_LAST_WORD =
		DEVTBL_WORDS + (DEV_COUNT - 1) * (DEV_MAPSZ_BYTES / (ARCHBITSZ / 8)) - 1;

	// Device table read word, descriptor or map size
	typedef union packed {
		struct packed {
			logic [14:0] rsvd;
			logic        useintr;
			logic [15:0] id;
		} desc;
		logic [ARCHBITSZ-1:0] mapsz;
	} devtbl_word_u;

endpackage

`default_nettype wire
